// ==== back_sub_input_vectors.txt ====
# Each frame on 3 lines: R rows 1-2, R rows 3-4 (row major, zeros below diagonal),
# then z1 z2 z3 z4 and expected x1 x2 x3 x4; 20-bit hex words with 15 fraction bits
08000 00000 00000 00000 00000 08000 00000 00000
00000 00000 08000 00000 00000 00000 00000 08000
0C000 EE000 04000 18000 0C000 EE000 04000 18000
10000 04000 F8000 02000 00000 F8000 10000 FC000
00000 00000 04000 08000 00000 00000 00000 20000
08000 18000 0C000 10000 0A000 06000 10000 04000
18000 00000 00000 00000 00000 E8000 00000 00000
00000 00000 18000 00000 00000 00000 00000 18000
08000 F8000 08000 F8000 02AAA 02AAA 02AAA FD556
00400 00000 00000 00000 00000 FF800 00000 00000
00000 00000 08000 00000 00000 00000 00000 08000
00001 00001 04000 FC000 0000F FFFF0 04000 FC000

// ==== back_sub_pipeline.sv ====
`timescale 1ns/1ps
`default_nettype none

module back_sub_pipeline #(
    parameter int IWL = bsub_pkg::DEFAULT_IWL,
    parameter int FWL = bsub_pkg::DEFAULT_FWL
) (
    input  wire                       clk,
    input  wire                       rst_n,
    tri_system_if.solver              sys,
    output logic                      out_valid,
    output logic signed [IWL+FWL-1:0] x1,
    output logic signed [IWL+FWL-1:0] x2,
    output logic signed [IWL+FWL-1:0] x3,
    output logic signed [IWL+FWL-1:0] x4
);
    import bsub_pkg::*;

    localparam int WL = IWL + FWL;

    // Fixed-point product truncated back to the word format
    function automatic logic signed [WL-1:0] fx_mul(input logic signed [WL-1:0] a,
                                                    input logic signed [WL-1:0] b);
        logic signed [2*WL-1:0] prod;
        prod = a * b;
        return prod[WL+FWL-1:FWL];
    endfunction

    logic [SOLVE_LATENCY-1:0] valid_sr;

    logic signed [WL-1:0] s1_rc11, s1_rc22, s1_rc33, s1_r12, s1_r13, s1_r14, s1_r23;
    logic signed [WL-1:0] s1_r24, s1_r34, s1_z1, s1_z2, s1_z3, s1_x4;
    logic signed [WL-1:0] s2_rc11, s2_rc22, s2_rc33, s2_r12, s2_r13, s2_r23;
    logic signed [WL-1:0] s2_x4r14, s2_x4r24, s2_z1, s2_z2, s2_d3, s2_x4;
    logic signed [WL-1:0] s3_rc11, s3_rc22, s3_r12, s3_r13, s3_r23, s3_x4r14;
    logic signed [WL-1:0] s3_x4r24, s3_z1, s3_z2, s3_x4, s3_x3;
    logic signed [WL-1:0] s4_rc11, s4_rc22, s4_r12, s4_x4r14, s4_x4r24;
    logic signed [WL-1:0] s4_z1, s4_x3r13, s4_d2, s4_x4, s4_x3;
    logic signed [WL-1:0] s5_rc11, s5_r12, s5_x4r14, s5_z1, s5_x3r13, s5_x4, s5_x3, s5_x2;
    logic signed [WL-1:0] s6_rc11, s6_x4r14, s6_d1, s6_x4, s6_x3, s6_x2;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_sr <= '0;
            {s1_rc11, s1_rc22, s1_rc33, s1_r12, s1_r13, s1_r14, s1_r23} <= '0;
            {s1_r24, s1_r34, s1_z1, s1_z2, s1_z3, s1_x4} <= '0;
            {s2_rc11, s2_rc22, s2_rc33, s2_r12, s2_r13, s2_r23} <= '0;
            {s2_x4r14, s2_x4r24, s2_z1, s2_z2, s2_d3, s2_x4} <= '0;
            {s3_rc11, s3_rc22, s3_r12, s3_r13, s3_r23, s3_x4r14} <= '0;
            {s3_x4r24, s3_z1, s3_z2, s3_x4, s3_x3} <= '0;
            {s4_rc11, s4_rc22, s4_r12, s4_x4r14, s4_x4r24} <= '0;
            {s4_z1, s4_x3r13, s4_d2, s4_x4, s4_x3} <= '0;
            {s5_rc11, s5_r12, s5_x4r14, s5_z1, s5_x3r13, s5_x4, s5_x3, s5_x2} <= '0;
            {s6_rc11, s6_x4r14, s6_d1, s6_x4, s6_x3, s6_x2} <= '0;
            {x1, x2, x3, x4} <= '0;
        end else begin
            valid_sr <= {valid_sr[SOLVE_LATENCY-2:0], sys.sys_valid};

            // --------------------------------------------------
            // Stage 1 forms x4
            s1_rc11 <= sys.diag_recip[0];
            s1_rc22 <= sys.diag_recip[1];
            s1_rc33 <= sys.diag_recip[2];
            s1_r12  <= sys.off_diag[0];
            s1_r13  <= sys.off_diag[1];
            s1_r14  <= sys.off_diag[2];
            s1_r23  <= sys.off_diag[3];
            s1_r24  <= sys.off_diag[4];
            s1_r34  <= sys.off_diag[5];
            s1_z1   <= sys.z[0];
            s1_z2   <= sys.z[1];
            s1_z3   <= sys.z[2];
            s1_x4   <= fx_mul(sys.diag_recip[3], sys.z[3]);

            // Stage 2 removes x4 from rows 1 to 3
            s2_rc11  <= s1_rc11;
            s2_rc22  <= s1_rc22;
            s2_rc33  <= s1_rc33;
            s2_r12   <= s1_r12;
            s2_r13   <= s1_r13;
            s2_r23   <= s1_r23;
            s2_x4r14 <= fx_mul(s1_x4, s1_r14);
            s2_x4r24 <= fx_mul(s1_x4, s1_r24);
            s2_z1    <= s1_z1;
            s2_z2    <= s1_z2;
            s2_d3    <= s1_z3 - fx_mul(s1_x4, s1_r34);
            s2_x4    <= s1_x4;

            // Stage 3 forms x3
            s3_rc11  <= s2_rc11;
            s3_rc22  <= s2_rc22;
            s3_r12   <= s2_r12;
            s3_r13   <= s2_r13;
            s3_r23   <= s2_r23;
            s3_x4r14 <= s2_x4r14;
            s3_x4r24 <= s2_x4r24;
            s3_z1    <= s2_z1;
            s3_z2    <= s2_z2;
            s3_x4    <= s2_x4;
            s3_x3    <= fx_mul(s2_rc33, s2_d3);

            // Stage 4
            s4_rc11  <= s3_rc11;
            s4_rc22  <= s3_rc22;
            s4_r12   <= s3_r12;
            s4_x4r14 <= s3_x4r14;
            s4_x4r24 <= s3_x4r24;
            s4_z1    <= s3_z1;
            s4_x3r13 <= fx_mul(s3_x3, s3_r13);
            s4_d2    <= s3_z2 - fx_mul(s3_x3, s3_r23);
            s4_x4    <= s3_x4;
            s4_x3    <= s3_x3;

            // Stage 5 forms x2
            s5_rc11  <= s4_rc11;
            s5_r12   <= s4_r12;
            s5_x4r14 <= s4_x4r14;
            s5_z1    <= s4_z1;
            s5_x3r13 <= s4_x3r13;
            s5_x4    <= s4_x4;
            s5_x3    <= s4_x3;
            s5_x2    <= fx_mul(s4_rc22, s4_d2 - s4_x4r24);

            // Stage 6
            s6_rc11  <= s5_rc11;
            s6_x4r14 <= s5_x4r14;
            s6_d1    <= s5_z1 - s5_x3r13 - fx_mul(s5_x2, s5_r12);
            s6_x4    <= s5_x4;
            s6_x3    <= s5_x3;
            s6_x2    <= s5_x2;

            // Stage 7 forms x1, solution held until the next result
            if (valid_sr[SOLVE_LATENCY-2]) begin
                x1 <= fx_mul(s6_d1 - s6_x4r14, s6_rc11);
                x2 <= s6_x2;
                x3 <= s6_x3;
                x4 <= s6_x4;
            end
        end
    end

    assign out_valid = valid_sr[SOLVE_LATENCY-1];

endmodule

`default_nettype wire

// ==== back_sub_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module back_sub_properties (
    input wire clk,
    input wire rst_n,
    input wire in_valid,
    input wire out_valid
);

    // --------------------------------------------------
    // Frame spacing and result timing
    // --------------------------------------------------
    // No frame start within seven cycles of the previous one
    assert property (@(posedge clk) disable iff (!rst_n)
        in_valid |-> !($past(in_valid, 1) || $past(in_valid, 2) || $past(in_valid, 3) ||
                       $past(in_valid, 4) || $past(in_valid, 5) || $past(in_valid, 6) ||
                       $past(in_valid, 7)))
        else $error("in_valid repeated within a frame");

    assert property (@(posedge clk) disable iff (!rst_n) in_valid |-> ##20 out_valid)
        else $error("out_valid missing 20 cycles after in_valid");

    // Results are single-cycle strobes
    assert property (@(posedge clk) disable iff (!rst_n) out_valid |=> !out_valid)
        else $error("out_valid high on two consecutive cycles");

    assert property (@(posedge clk) !rst_n |-> !out_valid)
        else $error("out_valid high during reset");

endmodule

bind back_sub_top back_sub_properties u_props (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .out_valid (out_valid)
);

`default_nettype wire

// ==== back_sub_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module back_sub_top #(
    parameter int IWL = bsub_pkg::DEFAULT_IWL,
    parameter int FWL = bsub_pkg::DEFAULT_FWL
) (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       in_valid,
    input  wire signed [IWL+FWL-1:0]  row1_data,
    input  wire signed [IWL+FWL-1:0]  row2_data,
    input  wire signed [IWL+FWL-1:0]  row3_data,
    input  wire signed [IWL+FWL-1:0]  row4_data,
    output logic                      out_valid,
    output logic signed [IWL+FWL-1:0] x1,
    output logic signed [IWL+FWL-1:0] x2,
    output logic signed [IWL+FWL-1:0] x3,
    output logic signed [IWL+FWL-1:0] x4
);

    localparam int WL = IWL + FWL;

    // One captured system per frame
    tri_system_if #(.WL(WL)) sys_bus ();

    row_capture #(.IWL(IWL), .FWL(FWL)) u_capture (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .row1_data (row1_data),
        .row2_data (row2_data),
        .row3_data (row3_data),
        .row4_data (row4_data),
        .sys       (sys_bus.capture)
    );

    back_sub_pipeline #(.IWL(IWL), .FWL(FWL)) u_solver (
        .clk       (clk),
        .rst_n     (rst_n),
        .sys       (sys_bus.solver),
        .out_valid (out_valid),
        .x1        (x1),
        .x2        (x2),
        .x3        (x3),
        .x4        (x4)
    );

endmodule

`default_nettype wire

// ==== bsub_pkg.sv ====
`default_nettype none

package bsub_pkg;

    // Word format, 5 integer and 15 fraction bits by default
    localparam int DEFAULT_IWL = 5;
    localparam int DEFAULT_FWL = 15;

    // Frame length and minimum in_valid spacing
    localparam int FRAME_BEATS = 8;

    // Register stages in the reciprocal divider and the solver
    localparam int RECIP_LATENCY = 6;
    localparam int SOLVE_LATENCY = 7;

    // Capture beats named after the words present on the lanes
    typedef enum logic [3:0] {
        BEAT_R11        = 4'd0,
        BEAT_R12        = 4'd1,
        BEAT_R13_R22    = 4'd2,
        BEAT_R14_R23    = 4'd3,
        BEAT_Z1_R24_R33 = 4'd4,
        BEAT_Z2_R34     = 4'd5,
        BEAT_Z3_R44     = 4'd6,
        BEAT_Z4         = 4'd7,
        BEAT_IDLE       = 4'd8
    } beat_e;

endpackage

`default_nettype wire

// ==== build.f ====
bsub_pkg.sv
tri_system_if.sv
recip_divider.sv
row_capture.sv
back_sub_pipeline.sv
back_sub_top.sv
back_sub_properties.sv
tb_back_sub.sv

// ==== recip_divider.sv ====
`timescale 1ns/1ps
`default_nettype none

module recip_divider #(
    parameter int IWL = bsub_pkg::DEFAULT_IWL,
    parameter int FWL = bsub_pkg::DEFAULT_FWL
) (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire signed [IWL+FWL-1:0]  divisor_in,
    output logic signed [IWL+FWL-1:0] recip_out
);
    import bsub_pkg::*;

    localparam int WL    = IWL + FWL;
    localparam int QBITS = WL - 1;
    localparam int STEPS = RECIP_LATENCY + 1;
    localparam int BPS   = (QBITS + STEPS - 1) / STEPS;

    // Magnitudes at or below this give a reciprocal that does not fit
    localparam logic [WL-1:0] SAT_LIMIT = WL'(1) << (FWL - IWL + 1);
    // 2^(2*FWL) aligned to the top quotient bit
    localparam logic [WL-1:0] REM_INIT  = WL'(1) << (FWL - IWL + 2);
    localparam logic signed [WL-1:0] MAX_POS = {1'b0, {(WL-1){1'b1}}};
    localparam logic signed [WL-1:0] MIN_NEG = {1'b1, {(WL-1){1'b0}}};

    logic [WL-1:0]            mag;
    logic                     sign_in;
    logic                     sat_in;
    logic [WL-1:0]            rem_in [STEPS];
    logic [WL-1:0]            rem_c [STEPS];
    logic [WL-1:0]            dvs_in [STEPS];
    logic [QBITS-1:0]         quo_in [STEPS];
    logic [QBITS-1:0]         quo_c [STEPS];
    logic [WL-1:0]            rem_q [RECIP_LATENCY];
    logic [WL-1:0]            dvs_q [RECIP_LATENCY];
    logic [QBITS-1:0]         quo_q [RECIP_LATENCY];
    logic [RECIP_LATENCY-1:0] sign_q;
    logic [RECIP_LATENCY-1:0] sat_q;
    logic signed [WL-1:0]     quo_ext;

    assign sign_in = divisor_in[WL-1];
    assign mag     = sign_in ? -divisor_in : divisor_in;
    assign sat_in  = (mag <= SAT_LIMIT);

    // --------------------------------------------------
    // Restoring division, BPS quotient bits per step
    // --------------------------------------------------
    always_comb begin
        logic [WL-1:0]    rem;
        logic [QBITS-1:0] quo;
        rem_in[0] = REM_INIT;
        quo_in[0] = '0;
        dvs_in[0] = mag;
        for (int s = 1; s < STEPS; s++) begin
            rem_in[s] = rem_q[s-1];
            quo_in[s] = quo_q[s-1];
            dvs_in[s] = dvs_q[s-1];
        end
        for (int s = 0; s < STEPS; s++) begin
            rem = rem_in[s];
            quo = quo_in[s];
            for (int b = QBITS - 1; b >= 0; b--) begin
                if ((QBITS - 1 - b) / BPS == s) begin
                    if (rem >= dvs_in[s]) begin
                        rem    = rem - dvs_in[s];
                        quo[b] = 1'b1;
                    end
                    rem = rem << 1;
                end
            end
            rem_c[s] = rem;
            quo_c[s] = quo;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rem_q  <= '{default: '0};
            quo_q  <= '{default: '0};
            dvs_q  <= '{default: '0};
            sign_q <= '0;
            sat_q  <= '0;
        end else begin
            for (int s = 0; s < RECIP_LATENCY; s++) begin
                rem_q[s] <= rem_c[s];
                quo_q[s] <= quo_c[s];
                dvs_q[s] <= dvs_in[s];
            end
            sign_q <= {sign_q[RECIP_LATENCY-2:0], sign_in};
            sat_q  <= {sat_q[RECIP_LATENCY-2:0], sat_in};
        end
    end

    // Sign restore and saturation on the last step
    assign quo_ext = {1'b0, quo_c[STEPS-1]};

    always_comb begin
        case ({sat_q[RECIP_LATENCY-1], sign_q[RECIP_LATENCY-1]})
            2'b00:   recip_out = quo_ext;
            2'b01:   recip_out = -quo_ext;
            2'b10:   recip_out = MAX_POS;
            default: recip_out = MIN_NEG;
        endcase
    end

endmodule

`default_nettype wire

// ==== row_capture.sv ====
`timescale 1ns/1ps
`default_nettype none

module row_capture #(
    parameter int IWL = bsub_pkg::DEFAULT_IWL,
    parameter int FWL = bsub_pkg::DEFAULT_FWL
) (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      in_valid,
    input  wire signed [IWL+FWL-1:0] row1_data,
    input  wire signed [IWL+FWL-1:0] row2_data,
    input  wire signed [IWL+FWL-1:0] row3_data,
    input  wire signed [IWL+FWL-1:0] row4_data,
    tri_system_if.capture            sys
);
    import bsub_pkg::*;

    localparam int WL  = IWL + FWL;
    localparam int TAP = RECIP_LATENCY - 1;

    beat_e                beat_q;
    beat_e                beat_now;
    beat_e                beat_d;
    beat_e                beat_dly [RECIP_LATENCY];
    logic signed [WL-1:0] lane_in [4];
    logic signed [WL-1:0] lane_dly [RECIP_LATENCY][4];
    logic signed [WL-1:0] div_in;
    logic signed [WL-1:0] recip;
    logic signed [WL-1:0] recip_q [4];
    logic signed [WL-1:0] off_q [6];
    logic signed [WL-1:0] z_q [3];

    // --------------------------------------------------
    // Beat counter, beat 0 is the in_valid cycle itself
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_q <= BEAT_IDLE;
        end else if (in_valid) begin
            beat_q <= BEAT_R12;
        end else if (beat_q == BEAT_Z4 || beat_q == BEAT_IDLE) begin
            beat_q <= BEAT_IDLE;
        end else begin
            beat_q <= beat_e'(beat_q + 1'b1);
        end
    end

    assign beat_now = in_valid ? BEAT_R11 : beat_q;

    always_comb lane_in = '{row1_data, row2_data, row3_data, row4_data};

    // Diagonal entries go to the divider as they arrive
    always_comb begin
        case (beat_now)
            BEAT_R11:        div_in = lane_in[0];
            BEAT_R13_R22:    div_in = lane_in[1];
            BEAT_Z1_R24_R33: div_in = lane_in[2];
            BEAT_Z3_R44:     div_in = lane_in[3];
            default:         div_in = '0;
        endcase
    end

    recip_divider #(.IWL(IWL), .FWL(FWL)) u_recip (
        .clk        (clk),
        .rst_n      (rst_n),
        .divisor_in (div_in),
        .recip_out  (recip)
    );

    // Lanes and beat wait for the divider result
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_dly <= '{default: BEAT_IDLE};
            lane_dly <= '{default: '0};
        end else begin
            beat_dly[0] <= beat_now;
            lane_dly[0] <= lane_in;
            for (int i = 1; i < RECIP_LATENCY; i++) begin
                beat_dly[i] <= beat_dly[i-1];
                lane_dly[i] <= lane_dly[i-1];
            end
        end
    end

    assign beat_d = beat_dly[TAP];

    // --------------------------------------------------
    // System registers
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            recip_q <= '{default: '0};
            off_q   <= '{default: '0};
            z_q     <= '{default: '0};
        end else begin
            case (beat_d)
                BEAT_R11:     recip_q[0] <= recip;
                BEAT_R12:     off_q[0] <= lane_dly[TAP][0];
                BEAT_R13_R22: begin
                    off_q[1]   <= lane_dly[TAP][0];
                    recip_q[1] <= recip;
                end
                BEAT_R14_R23: begin
                    off_q[2] <= lane_dly[TAP][0];
                    off_q[3] <= lane_dly[TAP][1];
                end
                BEAT_Z1_R24_R33: begin
                    z_q[0]     <= lane_dly[TAP][0];
                    off_q[4]   <= lane_dly[TAP][1];
                    recip_q[2] <= recip;
                end
                BEAT_Z2_R34: begin
                    z_q[1]   <= lane_dly[TAP][1];
                    off_q[5] <= lane_dly[TAP][2];
                end
                BEAT_Z3_R44: begin
                    z_q[2]     <= lane_dly[TAP][2];
                    recip_q[3] <= recip;
                end
                default: ;
            endcase
        end
    end

    assign sys.diag_recip = recip_q;
    assign sys.off_diag   = off_q;
    assign sys.z[0]       = z_q[0];
    assign sys.z[1]       = z_q[1];
    assign sys.z[2]       = z_q[2];
    // z4 comes straight off the delayed lane in the strobe cycle
    assign sys.z[3]       = lane_dly[TAP][3];
    assign sys.sys_valid  = (beat_d == BEAT_Z4);

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing --top-module tb_back_sub -f build.f -o tb_back_sub

./obj_dir/tb_back_sub 2>&1 | tee sim.log

if grep -q "CHECKS FAILED" sim.log || ! grep -q "ALL CHECKS PASSED" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"

// ==== tb_back_sub.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_back_sub;
    import bsub_pkg::*;

    localparam int IWL = DEFAULT_IWL;
    localparam int FWL = DEFAULT_FWL;
    localparam int WL = IWL + FWL;
    localparam int FILE_FRAMES = 4;
    localparam int RANDOM_FRAMES = 20;
    localparam int LATENCY = 20;
    localparam int CYCLE_LIMIT = (FILE_FRAMES + RANDOM_FRAMES) * FRAME_BEATS + LATENCY + 50;

    logic clk;
    logic rst_n;
    logic in_valid;
    logic signed [WL-1:0] row1_data, row2_data, row3_data, row4_data;
    wire out_valid;
    wire signed [WL-1:0] x1, x2, x3, x4;

    int cyc;
    int seed;
    int value_errors;
    int protocol_errors;
    int sent;
    int received;
    logic [4*WL-1:0] exp_q[$];
    string name_q[$];
    int start_q[$];

    back_sub_top #(.IWL(IWL), .FWL(FWL)) u_back_sub_top (
        .clk(clk), .rst_n(rst_n), .in_valid(in_valid),
        .row1_data(row1_data), .row2_data(row2_data),
        .row3_data(row3_data), .row4_data(row4_data),
        .out_valid(out_valid), .x1(x1), .x2(x2), .x3(x3), .x4(x4)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, %0d of %0d results seen", cyc, received, sent);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // --------------------------------------------------
    // Reference model
    // --------------------------------------------------
    function automatic logic signed [WL-1:0] mulq(input logic signed [WL-1:0] a,
                                                 input logic signed [WL-1:0] b);
        longint p;
        p = longint'(a) * longint'(b);
        p = p >>> FWL;
        return p[WL-1:0];
    endfunction

    // floor(2^(2*FWL)/|d|) with the sign put back and saturation for small |d|
    function automatic logic signed [WL-1:0] recip_ref(input logic signed [WL-1:0] d);
        longint v;
        longint mag;
        longint q;
        v = longint'(d);
        mag = (v < 0) ? -v : v;
        if (mag <= (longint'(1) << (FWL - IWL + 1)))
            return (v < 0) ? {1'b1, {(WL-1){1'b0}}} : {1'b0, {(WL-1){1'b1}}};
        q = (longint'(1) << (2 * FWL)) / mag;
        if (v < 0)
            q = -q;
        return q[WL-1:0];
    endfunction

    task automatic solve_model(input logic signed [WL-1:0] r[16], input logic signed [WL-1:0] z[4],
                               output logic [4*WL-1:0] x);
        logic signed [WL-1:0] xa, xb, xc, xd, x4r14, x4r24, x3r13, d1, d2, d3;
        xd = mulq(recip_ref(r[15]), z[3]);
        x4r14 = mulq(xd, r[3]);
        x4r24 = mulq(xd, r[7]);
        d3 = z[2] - mulq(xd, r[11]);
        xc = mulq(recip_ref(r[10]), d3);
        x3r13 = mulq(xc, r[2]);
        d2 = z[1] - mulq(xc, r[6]);
        xb = mulq(recip_ref(r[5]), d2 - x4r24);
        d1 = z[0] - x3r13 - mulq(xb, r[1]);
        xa = mulq(d1 - x4r14, recip_ref(r[0]));
        x = {xa, xb, xc, xd};
    endtask

    // --------------------------------------------------
    // Frame driver for the skewed lanes over eight beats
    // --------------------------------------------------
    task automatic send_frame(input logic signed [WL-1:0] r[16], input logic signed [WL-1:0] z[4],
                              input logic [4*WL-1:0] expected, input string name);
        for (int b = 0; b < FRAME_BEATS; b++) begin
            @(posedge clk);
            #1;
            in_valid = (b == 0);
            row1_data = '0;
            row2_data = '0;
            row3_data = '0;
            row4_data = '0;
            case (b)
                0: row1_data = r[0];
                1: row1_data = r[1];
                2: begin
                    row1_data = r[2];
                    row2_data = r[5];
                end
                3: begin
                    row1_data = r[3];
                    row2_data = r[6];
                end
                4: begin
                    row1_data = z[0];
                    row2_data = r[7];
                    row3_data = r[10];
                end
                5: begin
                    row2_data = z[1];
                    row3_data = r[11];
                end
                6: begin
                    row3_data = z[2];
                    row4_data = r[15];
                end
                default: row4_data = z[3];
            endcase
            if (b == 0) begin
                exp_q.push_back(expected);
                name_q.push_back(name);
                start_q.push_back(cyc);
                sent++;
            end
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
            in_valid = 1'b0;
            {row1_data, row2_data, row3_data, row4_data} = '0;
        end
    endtask

    task automatic check_word(input string name, input string field,
                              input logic signed [WL-1:0] exp, input logic signed [WL-1:0] act);
        assert (act === exp) else begin
            value_errors++;
            $display("Error %s %s expected %h actual %h", name, field, exp, act);
        end
    endtask

    // Outputs sampled on the falling edge between register updates
    always @(negedge clk) begin
        logic [4*WL-1:0] e;
        string n;
        int t;
        if (rst_n && out_valid) begin
            if (exp_q.size() == 0) begin
                protocol_errors++;
                $display("out_valid seen with no frame waiting for a result");
            end else begin
                e = exp_q.pop_front();
                n = name_q.pop_front();
                t = start_q.pop_front();
                received++;
                check_word(n, "x1", e[4*WL-1:3*WL], x1);
                check_word(n, "x2", e[3*WL-1:2*WL], x2);
                check_word(n, "x3", e[2*WL-1:WL], x3);
                check_word(n, "x4", e[WL-1:0], x4);
                assert (cyc - t == LATENCY) else begin
                    protocol_errors++;
                    $display("Result for %s came %0d cycles after in_valid", n, cyc - t);
                end
            end
        end else if (received == 0) begin
            assert ({x1, x2, x3, x4} === '0) else begin
                value_errors++;
                $display("Error reset x1..x4 expected 0 actual %h %h %h %h", x1, x2, x3, x4);
            end
        end
    end

    initial begin
        int fd;
        int code;
        int n_file;
        int drain;
        string line;
        logic signed [WL-1:0] f[24];
        logic signed [WL-1:0] r[16];
        logic signed [WL-1:0] z[4];
        logic [4*WL-1:0] x;
        clk = 1'b0;
        rst_n = 1'b0;
        in_valid = 1'b0;
        {row1_data, row2_data, row3_data, row4_data} = '0;
        cyc = 0;
        seed = 89;
        value_errors = 0;
        protocol_errors = 0;
        sent = 0;
        received = 0;
        n_file = 0;

        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;
        idle_cycles(4);

        // Directed frames
        fd = $fopen("back_sub_input_vectors.txt", "r");
        if (fd == 0) begin
            protocol_errors++;
            $display("Could not open back_sub_input_vectors.txt");
        end else begin
            code = $fgets(line, fd);
            code = $fgets(line, fd);
            while (!$feof(fd)) begin
                code = 1;
                for (int i = 0; i < 24 && code == 1; i++)
                    code = $fscanf(fd, " %h", f[i]);
                if (code != 1)
                    break;
                for (int i = 0; i < 16; i++)
                    r[i] = f[i];
                for (int i = 0; i < 4; i++)
                    z[i] = f[16+i];
                send_frame(r, z, {f[20], f[21], f[22], f[23]}, $sformatf("file_frame_%0d", n_file));
                idle_cycles(3);
                n_file++;
            end
            $fclose(fd);
        end
        assert (n_file == FILE_FRAMES) else begin
            protocol_errors++;
            $display("Vector file held %0d frames instead of %0d", n_file, FILE_FRAMES);
        end

        // Back-to-back random frames with diagonal magnitude 0.25 to 4.0
        for (int k = 0; k < RANDOM_FRAMES; k++) begin
            for (int i = 0; i < 16; i++)
                r[i] = $random(seed) % 65536;
            for (int i = 0; i < 4; i++) begin
                r[5*i] = 8192 + ($unsigned($random(seed)) % 122881);
                if ($random(seed) & 1)
                    r[5*i] = -r[5*i];
                z[i] = $random(seed) % 131072;
            end
            solve_model(r, z, x);
            send_frame(r, z, x, $sformatf("random_frame_%0d", k));
        end
        idle_cycles(1);

        // Outstanding results must arrive within their latency
        drain = 0;
        while (received < sent && drain < LATENCY + FRAME_BEATS) begin
            @(posedge clk);
            drain++;
        end
        idle_cycles(4);

        assert (received == sent && exp_q.size() == 0) else begin
            protocol_errors++;
            $display("Missing results, %0d of %0d frames produced output", received, sent);
        end
        $display("Value errors: %0d, protocol errors: %0d", value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tri_system_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface tri_system_if #(
    parameter int WL = bsub_pkg::DEFAULT_IWL + bsub_pkg::DEFAULT_FWL
);

    // Reciprocals of r11 to r44
    logic signed [WL-1:0] diag_recip [4];

    // Off-diagonal words in row order r12 r13 r14 r23 r24 r34
    logic signed [WL-1:0] off_diag [6];

    logic signed [WL-1:0] z [4];

    // Single-cycle strobe qualifying every word above
    logic                 sys_valid;

    modport capture (output diag_recip, off_diag, z, sys_valid);
    modport solver (input diag_recip, off_diag, z, sys_valid);

endinterface

`default_nettype wire
